/* logic/ahb_pkg.sv */
`default_nettype none

package ahb_pkg;

    localparam int AHB_A_WIDTH = 32;
    localparam int AHB_D_WIDTH = 32;
    localparam int AHB_LANES   = AHB_D_WIDTH / 8;

    typedef enum logic [1:0] {
        AHB_TRANS_IDLE   = 2'b00,
        AHB_TRANS_BUSY   = 2'b01,
        AHB_TRANS_NONSEQ = 2'b10,
        AHB_TRANS_SEQ    = 2'b11
    } ahb_trans_t;

    // Only sizes up to the bus width are supported
    typedef enum logic [2:0] {
        AHB_SIZE_BYTE = 3'b000,
        AHB_SIZE_HALF = 3'b001,
        AHB_SIZE_WORD = 3'b010
    } ahb_size_t;

    typedef enum logic {
        AHB_RESP_OKAY  = 1'b0,
        AHB_RESP_ERROR = 1'b1
    } ahb_resp_t;

    // Signals driven by the master
    typedef struct packed {
        logic                   hsel;
        logic [AHB_A_WIDTH-1:0] haddr;
        ahb_trans_t             htrans;
        ahb_size_t              hsize;
        logic                   hwrite;
        logic [AHB_D_WIDTH-1:0] hwdata;
    } ahb_req_t;

    // Signals driven by the slave
    typedef struct packed {
        logic [AHB_D_WIDTH-1:0] hrdata;
        logic                   hready;
        ahb_resp_t              hresp;
    } ahb_rsp_t;

endpackage

`default_nettype wire

/* logic/mmio_pkg.sv */
`default_nettype none

package mmio_pkg;

    import ahb_pkg::*;

    typedef logic [AHB_D_WIDTH-1:0] mmio_word_t;

    // Addresses are word addresses, zero-extended to the bus address width.
    // A write takes place whenever any byte enable is set
    typedef struct packed {
        logic [AHB_LANES-1:0]   wr_byteen;
        logic [AHB_A_WIDTH-1:0] wr_addr;
        mmio_word_t             wr_data;
        logic                   rd_en;
        logic [AHB_A_WIDTH-1:0] rd_addr;
    } mmio_req_t;

endpackage

`default_nettype wire

/* logic/ahb_lane_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module ahb_lane_decoder
    import ahb_pkg::*;
(
    input  logic [1:0]           offset,
    input  ahb_size_t            size,
    output logic [AHB_LANES-1:0] lanes
);

    localparam int LANE_BITS = $clog2(AHB_LANES);
    localparam int NUM_SIZES = LANE_BITS + 1;

    // Indexed as [offset][size][lane]
    logic [AHB_LANES-1:0][NUM_SIZES-1:0][AHB_LANES-1:0] lane_table;
    logic [2:0]                                          size_code;

    // A lane is enabled when it lies between the offset and offset + 2^size
    for (genvar off = 0; off < AHB_LANES; off++) begin : gen_offset
        for (genvar sz = 0; sz < NUM_SIZES; sz++) begin : gen_size
            for (genvar lane = 0; lane < AHB_LANES; lane++) begin : gen_lane
                assign lane_table[off][sz][lane] =
                    (lane >= off) && (lane < off + (1 << sz));
            end
        end
    end

    assign size_code = size;

    // Sizes wider than the bus select no lanes at all
    always_comb begin
        if (size_code < 3'(NUM_SIZES)) begin
            lanes = lane_table[offset][size_code[LANE_BITS-1:0]];
        end else begin
            lanes = '0;
        end
    end

endmodule

`default_nettype wire

/* logic/ahb2mmio.sv */
`timescale 1ns/10ps
`default_nettype none

module ahb2mmio
    import ahb_pkg::*;
    import mmio_pkg::*;
#(
    parameter int DEPTH = 256
) (
    input  logic       s_ahb,
    input  logic       reset,
    input  ahb_req_t   ahb_req,
    output ahb_rsp_t   ahb_rsp,
    output mmio_req_t  mmio_req,
    input  mmio_word_t rd_data
);

    localparam int LANE_BITS = $clog2(AHB_LANES);
    localparam int WORD_BITS = $clog2(DEPTH);

    logic                 active;
    logic                 rd_en;
    logic                 wr_cmd;
    logic [AHB_LANES-1:0] lanes;
    logic [WORD_BITS-1:0] word_addr;
    logic [AHB_LANES-1:0] wr_byteen_q;
    logic [WORD_BITS-1:0] wr_addr_q;

    ahb_lane_decoder lane_dec_i (
        .offset (ahb_req.haddr[LANE_BITS-1:0]),
        .size   (ahb_req.hsize),
        .lanes  (lanes)
    );

    // Only the address bits inside the memory are kept
    assign word_addr = ahb_req.haddr[LANE_BITS +: WORD_BITS];

    // IDLE and BUSY never start an access
    always_comb begin
        case (ahb_req.htrans)
            AHB_TRANS_NONSEQ,
            AHB_TRANS_SEQ: begin
                active = ahb_req.hsel;
            end
            default: begin
                active = 1'b0;
            end
        endcase
    end

    assign rd_en  = active && !ahb_req.hwrite;
    assign wr_cmd = active && ahb_req.hwrite;

    // Write address and lanes are held for the data phase, where hwdata arrives
    always_ff @(posedge s_ahb) begin
        if (reset) begin
            wr_byteen_q <= '0;
            wr_addr_q   <= '0;
        end else if (wr_cmd) begin
            wr_byteen_q <= lanes;
            wr_addr_q   <= word_addr;
        end else begin
            wr_byteen_q <= '0;
            wr_addr_q   <= '0;
        end
    end

    // Reads are issued straight from the address phase
    always_comb begin
        mmio_req.wr_byteen = wr_byteen_q;
        mmio_req.wr_addr   = AHB_A_WIDTH'(wr_addr_q);
        mmio_req.wr_data   = ahb_req.hwdata;
        mmio_req.rd_en     = rd_en;
        mmio_req.rd_addr   = AHB_A_WIDTH'(word_addr);
    end

    // The slave never stalls and never signals an error
    always_comb begin
        ahb_rsp.hrdata = rd_data;
        ahb_rsp.hready = 1'b1;
        ahb_rsp.hresp  = AHB_RESP_OKAY;
    end

endmodule

`default_nettype wire

/* logic/mmio_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module mmio_ram
    import ahb_pkg::*;
    import mmio_pkg::*;
#(
    parameter int DEPTH = 256
) (
    input  logic       s_ahb,
    input  logic       reset,
    input  mmio_req_t  mmio_req,
    output mmio_word_t rd_data
);

    localparam int WORD_BITS = $clog2(DEPTH);
    localparam int BYTE_W    = AHB_D_WIDTH / AHB_LANES;

    mmio_word_t           mem [DEPTH];
    logic [WORD_BITS-1:0] wr_word;
    logic [WORD_BITS-1:0] rd_word;
    logic                 same_word;
    mmio_word_t           rd_merged;

    assign wr_word   = mmio_req.wr_addr[WORD_BITS-1:0];
    assign rd_word   = mmio_req.rd_addr[WORD_BITS-1:0];
    assign same_word = (rd_word == wr_word);

    always_ff @(posedge s_ahb) begin
        for (int i = 0; i < AHB_LANES; i++) begin
            if (mmio_req.wr_byteen[i]) begin
                mem[wr_word][i*BYTE_W +: BYTE_W] <= mmio_req.wr_data[i*BYTE_W +: BYTE_W];
            end
        end
    end

    // Bytes being written this cycle take the place of the stored ones,
    // so a read right behind a write sees the new data
    always_comb begin
        rd_merged = mem[rd_word];
        if (same_word) begin
            for (int i = 0; i < AHB_LANES; i++) begin
                if (mmio_req.wr_byteen[i]) begin
                    rd_merged[i*BYTE_W +: BYTE_W] = mmio_req.wr_data[i*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    // Holds the last read word until the next read
    always_ff @(posedge s_ahb) begin
        if (reset) begin
            rd_data <= '0;
        end else if (mmio_req.rd_en) begin
            rd_data <= rd_merged;
        end
    end

endmodule

`default_nettype wire

/* logic/ahb_mmio_top.sv */
`timescale 1ns/10ps
`default_nettype none

module ahb_mmio_top
    import ahb_pkg::*;
    import mmio_pkg::*;
#(
    parameter int DEPTH = 256
) (
    input  logic     s_ahb,
    input  logic     reset,
    input  ahb_req_t ahb_req,
    output ahb_rsp_t ahb_rsp
);

    mmio_req_t  mmio_req;
    mmio_word_t rd_data;

    ahb2mmio #(
        .DEPTH (DEPTH)
    ) bridge_i (
        .s_ahb    (s_ahb),
        .reset    (reset),
        .ahb_req  (ahb_req),
        .ahb_rsp  (ahb_rsp),
        .mmio_req (mmio_req),
        .rd_data  (rd_data)
    );

    // Word memory behind the bridge, one cycle read latency
    mmio_ram #(
        .DEPTH (DEPTH)
    ) ram_i (
        .s_ahb    (s_ahb),
        .reset    (reset),
        .mmio_req (mmio_req),
        .rd_data  (rd_data)
    );

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic s_ahb,
    output logic reset
);

    initial begin
        s_ahb = 1'b0;
        forever #(PERIOD_NS / 2) s_ahb = ~s_ahb;
    end

    // Reset drops just after an edge, like every other driven input
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge s_ahb);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* test/ahb_mmio_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module ahb_mmio_assertions
    import ahb_pkg::*;
    import mmio_pkg::*;
(
    input logic      s_ahb,
    input logic      reset,
    input ahb_req_t  ahb_req,
    input ahb_rsp_t  ahb_rsp,
    input mmio_req_t mmio_req
);

    int   fail_count = 0;
    logic inactive;

    assign inactive = !ahb_req.hsel
                   || (ahb_req.htrans == AHB_TRANS_IDLE)
                   || (ahb_req.htrans == AHB_TRANS_BUSY);

    response_okay: assert property (@(posedge s_ahb) disable iff (reset)
        ahb_rsp.hready && (ahb_rsp.hresp == AHB_RESP_OKAY))
    else begin
        fail_count++;
        $error("Slave response is not ready with OKAY");
    end

    no_write_after_inactive: assert property (@(posedge s_ahb) disable iff (reset)
        inactive |=> (mmio_req.wr_byteen == '0))
    else begin
        fail_count++;
        $error("Byte enables set after an inactive transfer");
    end

    // At most two edges between set and clear lanes when padded with zeros
    contiguous_lanes: assert property (@(posedge s_ahb) disable iff (reset)
        $countones({mmio_req.wr_byteen, 1'b0} ^ {1'b0, mmio_req.wr_byteen}) <= 2)
    else begin
        fail_count++;
        $error("Byte enables are not contiguous");
    end

endmodule

`default_nettype wire

/* test/ahb_mmio_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module ahb_mmio_checker
    import ahb_pkg::*;
#(
    parameter int DEPTH = 256
) (
    input  logic     s_ahb,
    input  logic     reset,
    input  ahb_req_t ahb_req,
    input  ahb_rsp_t ahb_rsp,
    output int       err_count,
    output int       check_count
);

    localparam int NUM_BYTES = DEPTH * AHB_LANES;

    // Reference memory, one entry per byte, unwritten bytes stay X
    logic [7:0]  model [NUM_BYTES];
    int          errs = 0;
    int          checks = 0;
    logic        after_reset = 1'b0;
    logic        wr_pending = 1'b0;
    int          wr_word;
    int          wr_offset;
    int          wr_bytes;
    logic        rd_pending = 1'b0;
    logic [31:0] rd_addr;
    logic [31:0] rd_expect;

    assign err_count   = errs;
    assign check_count = checks;

    function automatic int word_of(input logic [31:0] addr);
        return int'((addr / AHB_LANES) % DEPTH);
    endfunction

    function automatic logic [31:0] model_word(input int word);
        logic [31:0] w;
        w = '0;
        for (int lane = AHB_LANES - 1; lane >= 0; lane--) begin
            w = (w << 8) | 32'(model[word * AHB_LANES + lane]);
        end
        return w;
    endfunction

    always @(posedge s_ahb) begin
        if (reset) begin
            wr_pending  = 1'b0;
            rd_pending  = 1'b0;
            after_reset = 1'b1;
        end else begin
            if (ahb_rsp.hready !== 1'b1 || ahb_rsp.hresp !== AHB_RESP_OKAY) begin
                errs++;
                $display("[FAIL] t=%0d ns: response hready=%b hresp=%b, expected ready and OKAY",
                         $time, ahb_rsp.hready, ahb_rsp.hresp);
            end
            if (after_reset) begin
                checks++;
                after_reset = 1'b0;
                if (ahb_rsp.hrdata !== 32'h0) begin
                    errs++;
                    $display("[FAIL] t=%0d ns: hrdata after reset expected 0x00000000, got 0x%08h",
                             $time, ahb_rsp.hrdata);
                end
            end
            if (rd_pending) begin
                checks++;
                if (ahb_rsp.hrdata !== rd_expect) begin
                    errs++;
                    $display("[FAIL] t=%0d ns: read 0x%08h expected 0x%08h, got 0x%08h",
                             $time, rd_addr, rd_expect, ahb_rsp.hrdata);
                end
            end
            // Data phase of the previous write, applied before this cycle's read
            if (wr_pending) begin
                for (int b = 0; b < wr_bytes; b++) begin
                    if (wr_offset + b < AHB_LANES) begin
                        model[wr_word * AHB_LANES + wr_offset + b] =
                            8'(ahb_req.hwdata >> ((wr_offset + b) * 8));
                    end
                end
            end
            wr_pending = 1'b0;
            rd_pending = 1'b0;
            if (ahb_req.hsel === 1'b1 &&
                (ahb_req.htrans == AHB_TRANS_NONSEQ || ahb_req.htrans == AHB_TRANS_SEQ)) begin
                if (ahb_req.hwrite) begin
                    wr_pending = 1'b1;
                    wr_word    = word_of(ahb_req.haddr);
                    wr_offset  = int'(ahb_req.haddr % AHB_LANES);
                    wr_bytes   = 1 << int'(ahb_req.hsize);
                end else begin
                    rd_pending = 1'b1;
                    rd_addr    = ahb_req.haddr;
                    rd_expect  = model_word(word_of(ahb_req.haddr));
                end
            end
        end
    end

endmodule

`default_nettype wire

/* test/ahb_mmio_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module ahb_mmio_tb
    import ahb_pkg::*;
();

    localparam int DEPTH     = 256;
    localparam int PERIOD_NS = 4;

    typedef struct packed {
        int                     test_id;
        ahb_trans_t             htrans;
        logic                   hsel;
        logic                   hwrite;
        ahb_size_t              hsize;
        logic [AHB_A_WIDTH-1:0] haddr;
        logic [AHB_D_WIDTH-1:0] hwdata;
    } stim_row_t;

    logic        s_ahb;
    logic        reset;
    ahb_req_t    ahb_req;
    ahb_rsp_t    ahb_rsp;
    int          err_count;
    int          check_count;
    stim_row_t   rows [$];
    logic        table_ready = 1'b0;
    logic [31:0] next_wdata;
    int          test_start_err = 0;
    int          num_tests = 0;
    string       test_names [1:6] = '{"reset state", "word write and read",
                                      "byte and halfword lanes", "write forwarding",
                                      "inactive transfers", "burst write and read"};

    tb_clock_gen #(
        .PERIOD_NS    (PERIOD_NS),
        .RESET_CYCLES (10)
    ) clock_gen_i (
        .s_ahb (s_ahb),
        .reset (reset)
    );

    ahb_mmio_top #(
        .DEPTH (DEPTH)
    ) dut_i (
        .s_ahb   (s_ahb),
        .reset   (reset),
        .ahb_req (ahb_req),
        .ahb_rsp (ahb_rsp)
    );

    ahb_mmio_checker #(
        .DEPTH (DEPTH)
    ) checker_i (
        .s_ahb       (s_ahb),
        .reset       (reset),
        .ahb_req     (ahb_req),
        .ahb_rsp     (ahb_rsp),
        .err_count   (err_count),
        .check_count (check_count)
    );

    bind ahb2mmio ahb_mmio_assertions assert_i (
        .s_ahb    (s_ahb),
        .reset    (reset),
        .ahb_req  (ahb_req),
        .ahb_rsp  (ahb_rsp),
        .mmio_req (mmio_req)
    );

    function automatic int total_errors();
        return err_count + dut_i.bridge_i.assert_i.fail_count;
    endfunction

    task automatic add_row(input int id, input ahb_trans_t trans, input logic sel,
                           input logic write, input ahb_size_t size,
                           input logic [31:0] addr, input logic [31:0] data);
        stim_row_t row;
        row.test_id = id;
        row.htrans  = trans;
        row.hsel    = sel;
        row.hwrite  = write;
        row.hsize   = size;
        row.haddr   = addr;
        row.hwdata  = data;
        rows.push_back(row);
    endtask

    task automatic write_sized(input int id, input ahb_size_t size,
                               input logic [31:0] addr, input logic [31:0] data);
        add_row(id, AHB_TRANS_NONSEQ, 1'b1, 1'b1, size, addr, data);
    endtask

    task automatic read_word(input int id, input logic [31:0] addr);
        add_row(id, AHB_TRANS_NONSEQ, 1'b1, 1'b0, AHB_SIZE_WORD, addr, 32'h0);
    endtask

    task automatic build_table();
        integer      seed;
        logic [31:0] data;
        ahb_trans_t  trans;
        seed = 32'hd8d2b045;
        add_row(1, AHB_TRANS_IDLE, 1'b0, 1'b0, AHB_SIZE_WORD, 32'h0, 32'h0);
        add_row(1, AHB_TRANS_IDLE, 1'b0, 1'b0, AHB_SIZE_WORD, 32'h0, 32'h0);
        write_sized(2, AHB_SIZE_WORD, 32'h000, 32'h0123_4567);
        write_sized(2, AHB_SIZE_WORD, 32'h004, 32'h89ab_cdef);
        write_sized(2, AHB_SIZE_WORD, 32'h040, 32'h5a5a_a5a5);
        write_sized(2, AHB_SIZE_WORD, 32'h3fc, 32'hfeed_f00d);
        read_word(2, 32'h000);
        read_word(2, 32'h004);
        read_word(2, 32'h040);
        read_word(2, 32'h3fc);
        write_sized(3, AHB_SIZE_WORD, 32'h080, 32'h0000_0000);
        write_sized(3, AHB_SIZE_BYTE, 32'h081, 32'h1122_3344);
        write_sized(3, AHB_SIZE_BYTE, 32'h083, 32'h5566_7788);
        read_word(3, 32'h080);
        write_sized(3, AHB_SIZE_BYTE, 32'h080, 32'h99aa_bbcc);
        write_sized(3, AHB_SIZE_BYTE, 32'h082, 32'hddee_ff00);
        read_word(3, 32'h080);
        write_sized(3, AHB_SIZE_WORD, 32'h088, 32'hffff_ffff);
        write_sized(3, AHB_SIZE_HALF, 32'h088, 32'h1234_abcd);
        read_word(3, 32'h088);
        write_sized(3, AHB_SIZE_HALF, 32'h08a, 32'h5678_ef01);
        read_word(3, 32'h088);
        // Each read sits in the data phase of the write just before it
        write_sized(4, AHB_SIZE_WORD, 32'h100, 32'hdead_beef);
        read_word(4, 32'h100);
        write_sized(4, AHB_SIZE_BYTE, 32'h101, 32'h0000_4200);
        read_word(4, 32'h100);
        write_sized(4, AHB_SIZE_HALF, 32'h102, 32'h7777_0000);
        read_word(4, 32'h100);
        write_sized(5, AHB_SIZE_WORD, 32'h140, 32'hcafe_f00d);
        add_row(5, AHB_TRANS_IDLE, 1'b1, 1'b1, AHB_SIZE_WORD, 32'h140, 32'h1111_1111);
        add_row(5, AHB_TRANS_BUSY, 1'b1, 1'b1, AHB_SIZE_WORD, 32'h140, 32'h2222_2222);
        add_row(5, AHB_TRANS_NONSEQ, 1'b0, 1'b1, AHB_SIZE_WORD, 32'h140, 32'h3333_3333);
        read_word(5, 32'h140);
        for (int k = 0; k < 8; k++) begin
            data = $random(seed);
            if (k == 0) trans = AHB_TRANS_NONSEQ;
            else trans = AHB_TRANS_SEQ;
            add_row(6, trans, 1'b1, 1'b1, AHB_SIZE_WORD, 32'h200 + 32'(k * 4), data);
        end
        for (int k = 0; k < 8; k++) begin
            if (k == 0) trans = AHB_TRANS_NONSEQ;
            else trans = AHB_TRANS_SEQ;
            add_row(6, trans, 1'b1, 1'b0, AHB_SIZE_WORD, 32'h200 + 32'(k * 4), 32'h0);
        end
    endtask

    // Address phase of this row, data phase of the row before
    task automatic drive_row(input stim_row_t row);
        ahb_req.hsel   = row.hsel;
        ahb_req.htrans = row.htrans;
        ahb_req.hwrite = row.hwrite;
        ahb_req.hsize  = row.hsize;
        ahb_req.haddr  = row.haddr;
        ahb_req.hwdata = next_wdata;
        next_wdata     = row.hwdata;
    endtask

    task automatic drive_idle();
        ahb_req.hsel   = 1'b0;
        ahb_req.htrans = AHB_TRANS_IDLE;
        ahb_req.hwrite = 1'b0;
        ahb_req.hwdata = next_wdata;
        next_wdata     = '0;
    endtask

    task automatic report_test(input int id);
        int errs;
        errs = total_errors() - test_start_err;
        num_tests++;
        if (errs == 0) $display("Test %0d (%s): PASS", id, test_names[id]);
        else $display("Test %0d (%s): FAIL with %0d errors", id, test_names[id], errs);
        test_start_err = total_errors();
    endtask

    initial begin
        ahb_req    = '0;
        next_wdata = '0;
        build_table();
        table_ready = 1'b1;
        wait (reset === 1'b0);
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge s_ahb);
            #1;
            drive_row(rows[i]);
            if (i == rows.size() - 1 || rows[i + 1].test_id != rows[i].test_id) begin
                // Two idle cycles let the last data phase and read check complete
                repeat (2) begin
                    @(posedge s_ahb);
                    #1;
                    drive_idle();
                end
                report_test(rows[i].test_id);
            end
        end
        $display("Done: %0d tests, %0d checks, %0d errors", num_tests, check_count,
                 total_errors());
        if (total_errors() == 0 && check_count > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        int limit_ns;
        wait (table_ready);
        limit_ns = (rows.size() + 20) * PERIOD_NS * 2;
        #(limit_ns);
        $display("Timeout: the stimulus did not finish within %0d ns", limit_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
logic/ahb_pkg.sv
logic/mmio_pkg.sv
logic/ahb_lane_decoder.sv
logic/ahb2mmio.sv
logic/mmio_ram.sv
logic/ahb_mmio_top.sv
test/tb_clock_gen.sv
test/ahb_mmio_assertions.sv
test/ahb_mmio_checker.sv
test/ahb_mmio_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := ahb_mmio_tb
FLIST      := flist.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP)
LINT_FLAGS := --lint-only -Wall --timing --assert --top-module $(TOP)
SIM_ARGS   := +verilator+error+limit+100
LOG        := sim.log
PASS_MSG   := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
